/* filelist.f */
design/wb_pkg.sv
design/cpu_pkg.sv
design/cpu_fetch.sv
design/cpu_exec.sv
design/wb_arbiter.sv
design/cpu_top.sv
verification/wb_mem_model.sv
verification/tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_cpu_top \
	-Mdir obj_dir \
	-f filelist.f

./obj_dir/Vtb_cpu_top

/* verification/tb_cpu_top.sv */
// testbench for the core: clock, reset, program and expected-write tables, compare tasks
`timescale 1ns/1ps

module tb_cpu_top;

	localparam int          N_PROG    = 20;
	localparam int          N_WR      = 8;
	localparam int          RUN_LIMIT = 3000;
	localparam int          DRAIN     = 20;
	localparam logic [31:0] PRESET    = 32'h1234_5678;

	logic            clk;
	logic            reset;
	wb_pkg::wb_req_t bus_req;
	wb_pkg::wb_rsp_t bus_rsp;
	wb_pkg::wb_req_t wr_mon;
	wb_pkg::wb_req_t rd_mon;

	cpu_pkg::inst_t  prog   [N_PROG];
	wb_pkg::wb_req_t exp_wr [N_WR];
	int              wr_count;
	logic [31:2]     exp_pc;
	int              cycles;

	cpu_top #(
		.RESET_VECTOR (32'h0000_0000)
	) u_cpu_top (
		.clk       (clk),
		.reset     (reset),
		.bus_req_o (bus_req),
		.bus_rsp_i (bus_rsp)
	);

	wb_mem_model u_mem (
		.clk      (clk),
		.reset    (reset),
		.req_i    (bus_req),
		.rsp_o    (bus_rsp),
		.wr_mon_o (wr_mon),
		.rd_mon_o (rd_mon)
	);

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	// --------------------------------------------------
	//  instruction and table builders
	// --------------------------------------------------

	function automatic cpu_pkg::inst_t encode_i(input logic [5:0] op,
			input cpu_pkg::reg_idx_t rs, input cpu_pkg::reg_idx_t rt,
			input logic [15:0] imm);
		cpu_pkg::inst_t w;
		w.i.op  = op;
		w.i.rs  = rs;
		w.i.rt  = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic cpu_pkg::inst_t encode_r(input cpu_pkg::reg_idx_t rs,
			input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t rd,
			input logic [5:0] funct);
		cpu_pkg::inst_t w;
		w.r.op    = cpu_pkg::OP_SPECIAL;
		w.r.rs    = rs;
		w.r.rt    = rt;
		w.r.rd    = rd;
		w.r.shamt = 5'd0;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic wb_pkg::wb_req_t make_write(input logic [31:0] byte_adr,
			input logic [31:0] dat, input logic [3:0] sel);
		wb_pkg::wb_req_t r;
		r     = '0;
		r.adr = byte_adr[31:2];
		r.dat = dat;
		r.we  = 1'b1;
		r.sel = sel;
		r.stb = 1'b1;
		return r;
	endfunction

	// --------------------------------------------------
	//  compare tasks
	// --------------------------------------------------

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		$display("tests failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_words(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_write(input wb_pkg::wb_req_t got, input wb_pkg::wb_req_t exp);
		if (got.adr != exp.adr) begin
			report_value("write adr", {got.adr, 2'b00}, {exp.adr, 2'b00});
		end else if (got.dat != exp.dat) begin
			report_value("write dat", got.dat, exp.dat);
		end else if (got.sel != exp.sel) begin
			report_value("write sel", 32'(got.sel), 32'(exp.sel));
		end
	endtask

	task automatic check_read(input wb_pkg::wb_req_t got, input logic [31:2] exp_adr);
		if (got.adr != exp_adr) begin
			report_value("fetch adr", {got.adr, 2'b00}, {exp_adr, 2'b00});
		end
	endtask

	// --------------------------------------------------
	//  monitors, sampled away from the active edge
	// --------------------------------------------------

	always @(negedge clk) begin
		if (!reset) begin
			if (wr_mon.stb) begin
				if (wr_count >= N_WR) begin
					report_words("a write appeared beyond the expected table");
				end else begin
					check_write(wr_mon, exp_wr[wr_count]);
				end
				wr_count = wr_count + 1;
			end
			// instruction reads live below the data region
			if (rd_mon.stb && ({rd_mon.adr, 2'b00} < 32'h100)) begin
				check_read(rd_mon, exp_pc);
				exp_pc = exp_pc + 30'd1;
			end
		end
	end

	// --------------------------------------------------
	//  main sequence
	// --------------------------------------------------

	initial begin
		void'($urandom(32'h1c29_8511));
		reset    = 1'b1;
		wr_count = 0;
		exp_pc   = 30'd0;

		// sum chain, then a load and increment
		prog[0]  = encode_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0012);
		prog[1]  = encode_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd2, 16'h7ff0);
		prog[2]  = encode_i(cpu_pkg::OP_ADDIU, 5'd1, 5'd3, 16'hffff);
		prog[3]  = encode_r(5'd1, 5'd2, 5'd4, cpu_pkg::FN_ADDU);
		prog[4]  = encode_r(5'd4, 5'd3, 5'd4, cpu_pkg::FN_ADDU);
		prog[5]  = encode_i(cpu_pkg::OP_SW, 5'd0, 5'd4, 16'h0140);
		prog[6]  = encode_i(cpu_pkg::OP_LW, 5'd0, 5'd5, 16'h0100);
		prog[7]  = encode_i(cpu_pkg::OP_ADDIU, 5'd5, 5'd6, 16'h0123);
		prog[8]  = encode_i(cpu_pkg::OP_SW, 5'd0, 5'd6, 16'h0144);
		// byte lanes
		prog[9]  = encode_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd7, 16'h00a5);
		prog[10] = encode_i(cpu_pkg::OP_SB, 5'd0, 5'd7, 16'h0150);
		prog[11] = encode_i(cpu_pkg::OP_SB, 5'd0, 5'd7, 16'h0151);
		prog[12] = encode_i(cpu_pkg::OP_SB, 5'd0, 5'd7, 16'h0152);
		prog[13] = encode_i(cpu_pkg::OP_SB, 5'd0, 5'd7, 16'h0153);
		// r0 and no-op checks
		prog[14] = encode_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0077);
		prog[15] = encode_i(cpu_pkg::OP_SW, 5'd0, 5'd0, 16'h0148);
		prog[16] = encode_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd9, 16'h0055);
		prog[17] = encode_i(6'h3f, 5'd0, 5'd9, 16'h1234);
		prog[18] = encode_r(5'd1, 5'd2, 5'd9, 6'h20);
		prog[19] = encode_i(cpu_pkg::OP_SW, 5'd0, 5'd9, 16'h014c);

		exp_wr[0] = make_write(32'h140,
			32'h12 + 32'h7ff0 + (32'h12 + 32'hffff_ffff), 4'hf);
		exp_wr[1] = make_write(32'h144, PRESET + 32'h123, 4'hf);
		exp_wr[2] = make_write(32'h150, {4{8'ha5}}, 4'b0001);
		exp_wr[3] = make_write(32'h151, {4{8'ha5}}, 4'b0010);
		exp_wr[4] = make_write(32'h152, {4{8'ha5}}, 4'b0100);
		exp_wr[5] = make_write(32'h153, {4{8'ha5}}, 4'b1000);
		exp_wr[6] = make_write(32'h148, 32'h0, 4'hf);
		exp_wr[7] = make_write(32'h14c, 32'h55, 4'hf);

		// zero words below 0x100 decode as no-ops
		for (int i = 0; i < 256; i++) begin
			if (i < 64) begin
				u_mem.mem[i] = 32'h0;
			end else begin
				u_mem.mem[i] = 32'hd00d_0000 ^ (32'(i) * 32'h0001_0403);
			end
		end
		for (int i = 0; i < N_PROG; i++) begin
			u_mem.mem[i] = prog[i];
		end
		u_mem.mem[32'h100 >> 2] = PRESET;

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		cycles = 0;
		while ((wr_count < N_WR) && (cycles < RUN_LIMIT)) begin
			@(negedge clk);
			cycles = cycles + 1;
		end

		// a few more cycles to catch stray writes
		cycles = 0;
		while ((wr_count >= N_WR) && (cycles < DRAIN)) begin
			@(negedge clk);
			cycles = cycles + 1;
		end

		if (wr_count == N_WR) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("timeout: only %0d of %0d writes completed", wr_count, N_WR);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

endmodule

/* verification/wb_mem_model.sv */
// word memory bus slave with random acknowledge delay and read and write monitor outputs
`timescale 1ns/1ps

module wb_mem_model (
	input  logic             clk,
	input  logic             reset,
	input  wb_pkg::wb_req_t  req_i,
	output wb_pkg::wb_rsp_t  rsp_o,
	output wb_pkg::wb_req_t  wr_mon_o,
	output wb_pkg::wb_req_t  rd_mon_o
);

	// 1 KiB of words, loaded by the testbench before reset falls
	logic [31:0] mem [256];
	logic        active;
	logic [1:0]  cnt;
	logic        ack;
	logic [31:0] rdat;

	assign rsp_o.dat = rdat;
	assign rsp_o.ack = ack;

	// --------------------------------------------------
	//  transfer handling
	// --------------------------------------------------

	always @(posedge clk or posedge reset) begin : serve
		logic [1:0] delay;
		logic       fire;
		if (reset) begin
			active   <= 1'b0;
			cnt      <= 2'd0;
			ack      <= 1'b0;
			rdat     <= 32'd0;
			wr_mon_o <= '0;
			rd_mon_o <= '0;
		end else begin
			ack          <= 1'b0;
			wr_mon_o.stb <= 1'b0;
			rd_mon_o.stb <= 1'b0;
			fire = 1'b0;
			// the ack cycle itself never starts a new transfer
			if (req_i.stb && !ack) begin
				if (!active) begin
					delay = 2'($urandom % 4);
					if (delay == 2'd0) begin
						fire = 1'b1;
					end else begin
						active <= 1'b1;
						cnt    <= delay - 2'd1;
					end
				end else if (cnt == 2'd0) begin
					fire = 1'b1;
				end else begin
					cnt <= cnt - 2'd1;
				end
			end
			if (fire) begin
				active <= 1'b0;
				ack    <= 1'b1;
				if (req_i.we) begin
					for (int b = 0; b < 4; b++) begin
						if (req_i.sel[b]) begin
							mem[req_i.adr[9:2]][8*b +: 8] = req_i.dat[8*b +: 8];
						end
					end
					wr_mon_o <= req_i;
				end else begin
					rdat     <= mem[req_i.adr[9:2]];
					rd_mon_o <= req_i;
				end
			end
		end
	end

endmodule

/* design/cpu_top.sv */
// core top level wiring fetch, execute and bus arbiter
`timescale 1ns/1ps

module cpu_top #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             reset,
	output wb_pkg::wb_req_t  bus_req_o,
	input  wb_pkg::wb_rsp_t  bus_rsp_i
);

	wb_pkg::wb_req_t fetch_req;
	wb_pkg::wb_rsp_t fetch_rsp;
	wb_pkg::wb_req_t data_req;
	wb_pkg::wb_rsp_t data_rsp;
	cpu_pkg::inst_t  inst;
	logic            inst_stb;
	logic            busy;

	// --------------------------------------------------
	//  pipeline
	// --------------------------------------------------

	cpu_fetch #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_fetch (
		.clk        (clk),
		.reset      (reset),
		.busy_i     (busy),
		.req_o      (fetch_req),
		.rsp_i      (fetch_rsp),
		.inst_o     (inst),
		.inst_stb_o (inst_stb)
	);

	cpu_exec u_exec (
		.clk        (clk),
		.reset      (reset),
		.inst_i     (inst),
		.inst_stb_i (inst_stb),
		.busy_o     (busy),
		.req_o      (data_req),
		.rsp_i      (data_rsp)
	);

	// both masters share the external bus
	wb_arbiter u_arbiter (
		.clk         (clk),
		.reset       (reset),
		.fetch_req_i (fetch_req),
		.data_req_i  (data_req),
		.fetch_rsp_o (fetch_rsp),
		.data_rsp_o  (data_rsp),
		.bus_req_o   (bus_req_o),
		.bus_rsp_i   (bus_rsp_i)
	);

endmodule

/* design/wb_arbiter.sv */
// two-master bus arbiter with data priority and a grant held until acknowledge
`timescale 1ns/1ps

module wb_arbiter (
	input  logic             clk,
	input  logic             reset,
	input  wb_pkg::wb_req_t  fetch_req_i,
	input  wb_pkg::wb_req_t  data_req_i,
	output wb_pkg::wb_rsp_t  fetch_rsp_o,
	output wb_pkg::wb_rsp_t  data_rsp_o,
	output wb_pkg::wb_req_t  bus_req_o,
	input  wb_pkg::wb_rsp_t  bus_rsp_i
);

	logic pend;
	logic sel_q;
	// high selects the data master
	logic sel;

	// --------------------------------------------------
	//  grant
	// --------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pend  <= 1'b0;
			sel_q <= 1'b0;
		end else begin
			pend <= bus_req_o.stb & !bus_rsp_i.ack;
			if (!pend) begin
				sel_q <= sel;
			end
		end
	end

	// idle bus goes to data whenever it asks
	assign sel = pend ? sel_q : data_req_i.stb;

	// --------------------------------------------------
	//  request mux and ack steering
	// --------------------------------------------------

	assign bus_req_o = sel ? data_req_i : fetch_req_i;

	assign fetch_rsp_o.dat = bus_rsp_i.dat;
	assign fetch_rsp_o.ack = !sel & bus_rsp_i.ack;
	assign data_rsp_o.dat  = bus_rsp_i.dat;
	assign data_rsp_o.ack  = sel & bus_rsp_i.ack;

	// a granted transfer keeps its master until the ack
	a_grant_held: assert property (
		@(posedge clk) disable iff (reset)
		(bus_req_o.stb && !bus_rsp_i.ack) |=> (bus_req_o.stb && $stable(bus_req_o))
	);

endmodule

/* design/cpu_exec.sv */
// execute unit with decode, register file, adder and load/store bus requests
`timescale 1ns/1ps

module cpu_exec (
	input  logic             clk,
	input  logic             reset,
	input  cpu_pkg::inst_t   inst_i,
	input  logic             inst_stb_i,
	output logic             busy_o,
	output wb_pkg::wb_req_t  req_o,
	input  wb_pkg::wb_rsp_t  rsp_i
);

	logic [31:0]       regs [32];
	logic [5:0]        op;
	logic [31:0]       rs_val;
	logic [31:0]       rt_val;
	logic [31:0]       imm_ext;
	logic [31:0]       eff_adr;
	logic              is_addu;
	logic              is_mem;
	logic              alu_we;
	cpu_pkg::reg_idx_t alu_idx;
	logic [31:0]       alu_res;
	logic              load_we;
	logic              mem_pend;
	wb_pkg::wb_req_t   mem_req_q;
	cpu_pkg::reg_idx_t ld_rt;

	// --------------------------------------------------
	//  decode
	// --------------------------------------------------

	assign op      = inst_i.i.op;
	assign is_addu = (op == cpu_pkg::OP_SPECIAL) && (inst_i.r.funct == cpu_pkg::FN_ADDU);
	assign is_mem  = (op == cpu_pkg::OP_LW) || (op == cpu_pkg::OP_SW) || (op == cpu_pkg::OP_SB);

	// r0 always reads zero
	assign rs_val  = (inst_i.r.rs == 5'd0) ? 32'd0 : regs[inst_i.r.rs];
	assign rt_val  = (inst_i.i.rt == 5'd0) ? 32'd0 : regs[inst_i.i.rt];
	assign imm_ext = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
	assign eff_adr = rs_val + imm_ext;

	// --------------------------------------------------
	//  register file
	// --------------------------------------------------

	always_comb begin
		alu_we  = 1'b0;
		alu_idx = inst_i.i.rt;
		alu_res = eff_adr;
		if (inst_stb_i) begin
			if (is_addu) begin
				alu_we  = 1'b1;
				alu_idx = inst_i.r.rd;
				alu_res = rs_val + rt_val;
			end else if (op == cpu_pkg::OP_ADDIU) begin
				alu_we = 1'b1;
			end
		end
	end

	// load data lands in the ack cycle
	assign load_we = mem_pend & !mem_req_q.we & rsp_i.ack;

	always_ff @(posedge clk) begin
		if (load_we) begin
			regs[ld_rt] <= rsp_i.dat;
		end else if (alu_we) begin
			regs[alu_idx] <= alu_res;
		end
	end

	// --------------------------------------------------
	//  load/store requests
	// --------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mem_pend <= 1'b0;
		end else if (inst_stb_i && is_mem) begin
			mem_pend <= 1'b1;
		end else if (mem_pend && rsp_i.ack) begin
			mem_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_stb_i && is_mem) begin
			mem_req_q.adr <= eff_adr[31:2];
			mem_req_q.we  <= (op != cpu_pkg::OP_LW);
			mem_req_q.stb <= 1'b1;
			ld_rt         <= inst_i.i.rt;
			if (op == cpu_pkg::OP_SB) begin
				// byte on every lane, one lane enabled
				mem_req_q.dat <= {4{rt_val[7:0]}};
				mem_req_q.sel <= 4'b0001 << eff_adr[1:0];
			end else begin
				mem_req_q.dat <= rt_val;
				mem_req_q.sel <= 4'hf;
			end
		end
	end

	always_comb begin
		req_o     = mem_req_q;
		req_o.stb = mem_pend;
	end

	// busy spans the whole data transfer
	assign busy_o = mem_pend;

	// --------------------------------------------------
	//  assertions
	// --------------------------------------------------

	// fetch must hold its buffer during a data access
	a_no_inst_while_busy: assert property (
		@(posedge clk) disable iff (reset)
		busy_o |-> !inst_stb_i
	);

	a_req_stable: assert property (
		@(posedge clk) disable iff (reset)
		(req_o.stb && !rsp_i.ack) |=> (req_o.stb && $stable(req_o.adr) &&
			$stable(req_o.dat) && $stable(req_o.we) && $stable(req_o.sel))
	);

endmodule

/* design/cpu_fetch.sv */
// instruction fetch unit with program counter and one-entry instruction buffer
`timescale 1ns/1ps

module cpu_fetch #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             busy_i,
	output wb_pkg::wb_req_t  req_o,
	input  wb_pkg::wb_rsp_t  rsp_i,
	output cpu_pkg::inst_t   inst_o,
	output logic             inst_stb_o
);

	logic [31:2]    pc;
	logic           rd_stb;
	logic           buf_full;
	cpu_pkg::inst_t inst_buf;

	// handover to exec empties the buffer
	assign inst_stb_o = buf_full & !busy_i;
	assign inst_o     = inst_buf;

	// --------------------------------------------------
	//  read control
	// --------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc       <= RESET_VECTOR[31:2];
			rd_stb   <= 1'b0;
			buf_full <= 1'b0;
		end else begin
			if (rd_stb && rsp_i.ack) begin
				rd_stb   <= 1'b0;
				buf_full <= 1'b1;
				pc       <= pc + 30'd1;
			end else if (!rd_stb && (!buf_full || inst_stb_o)) begin
				// next read starts right after the handover
				rd_stb <= 1'b1;
			end
			if (inst_stb_o) begin
				buf_full <= 1'b0;
			end
		end
	end

	// instruction word captured on the ack
	always_ff @(posedge clk) begin
		if (rd_stb && rsp_i.ack) begin
			inst_buf <= rsp_i.dat;
		end
	end

	// reads only, full word
	always_comb begin
		req_o     = '0;
		req_o.adr = pc;
		req_o.we  = 1'b0;
		req_o.sel = 4'hf;
		req_o.stb = rd_stb;
	end

endmodule

/* design/cpu_pkg.sv */
// instruction formats, instruction word union, opcode and function codes, register index
package cpu_pkg;

	// register number
	typedef logic [4:0] reg_idx_t;

	// --------------------------------------------------
	//  instruction formats
	// --------------------------------------------------

	// register format
	typedef struct packed {
		logic [5:0] op;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// immediate format
	typedef struct packed {
		logic [5:0]  op;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_fields_t;

	// one fetched word, seen through either format
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} inst_t;

	// --------------------------------------------------
	//  opcodes
	// --------------------------------------------------

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// function field under OP_SPECIAL
	localparam logic [5:0] FN_ADDU    = 6'h21;

endpackage

/* design/wb_pkg.sv */
// shared wishbone-style bus request and response structs
package wb_pkg;

	// --------------------------------------------------
	//  master to slave
	// --------------------------------------------------

	// adr is a word address, byte lanes chosen by sel
	typedef struct packed {
		logic [31:2] adr;
		logic [31:0] dat;
		logic        we;
		logic [3:0]  sel;
		logic        stb;
	} wb_req_t;

	// --------------------------------------------------
	//  slave to master
	// --------------------------------------------------

	// ack is a single-cycle pulse that ends the transfer
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

endpackage
